// ==== all.f ====
+incdir+logic
logic/aes_pkg.sv
logic/aes_sbox.sv
logic/aes_key_expand.sv
logic/aes_round.sv
logic/aes_round_ctrl.sv
logic/aes_state_store.sv
logic/aes_core.sv
tb/tb_aes_core.sv

// ==== logic/aes_config.svh ====
`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// AES-128 round parameters
////////////////////////////////////////////////////////////////////////////

// Full rounds after the initial AddRoundKey
`define AES_NR 10

// Counter must hold 0 to AES_NR
`define AES_ROUND_W 4

`endif

// ==== logic/aes_core.sv ====
`timescale 1ns/1ps

module aes_core
	import aes_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n_i,
	input  logic       load_i,
	input  aes_block_t key_i,
	input  aes_block_t data_i,
	output aes_block_t data_o,
	output logic       busy_o
);

	logic       round_step;
	logic       round_first;
	logic       round_last;
	aes_block_t round_key;
	aes_block_t state;
	aes_block_t next_state;

	aes_round_ctrl u_ctrl (
		.clk     (clk),
		.arst_n_i(arst_n_i),
		.load_i  (load_i),
		.busy_o  (busy_o),
		.step_o  (round_step),
		.first_o (round_first),
		.last_o  (round_last)
	);

	aes_key_expand u_key (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.load_i     (load_i),
		.step_i     (round_step),
		.key_i      (key_i),
		.round_key_o(round_key)
	);

	aes_round u_round (
		.state_i     (state),
		.round_key_i (round_key),
		.first_i     (round_first),
		.last_i      (round_last),
		.next_state_o(next_state)
	);

	aes_state_store u_store (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.load_i      (load_i),
		.step_i      (round_step),
		.last_i      (round_last),
		.data_i      (data_i),
		.next_state_i(next_state),
		.state_o     (state),
		.data_o      (data_o)
	);

endmodule

// ==== logic/aes_key_expand.sv ====
`timescale 1ns/1ps

module aes_key_expand
	import aes_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n_i,
	input  logic       load_i,
	input  logic       step_i,
	input  aes_block_t key_i,
	output aes_block_t round_key_o
);

	aes_block_t key_q;
	aes_block_t key_next;
	aes_byte_t  rcon_q;
	aes_word_t  rot_word;
	aes_word_t  sub_word;
	aes_word_t  temp_word;

	////////////////////////////////////////////////////////////////////////////
	// SubWord(RotWord(w3)) ^ Rcon
	////////////////////////////////////////////////////////////////////////////

	assign rot_word = {key_q[3][1], key_q[3][2], key_q[3][3], key_q[3][0]};

	genvar i;
	generate
		for (i = 0; i < 4; i++)
		begin : g_sub_word
			aes_sbox u_sbox (
				.byte_i(rot_word[i]),
				.byte_o(sub_word[i])
			);
		end
	endgenerate

	assign temp_word = sub_word ^ {rcon_q, 24'h000000};

	// Word recurrence where each word chains on the one before
	always_comb
	begin
		key_next[0] = key_q[0] ^ temp_word;
		key_next[1] = key_q[1] ^ key_next[0];
		key_next[2] = key_q[2] ^ key_next[1];
		key_next[3] = key_q[3] ^ key_next[2];
	end

	always_ff @(posedge clk)
	begin
		if (load_i)
			key_q <= key_i;
		else if (step_i)
			key_q <= key_next;
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			rcon_q <= 8'h01;
		else if (load_i)
			rcon_q <= 8'h01;
		else if (step_i)
			rcon_q <= gf_xtime(rcon_q);
	end

	assign round_key_o = key_q;

	a_rcon_nonzero: assert property (@(posedge clk) disable iff (!arst_n_i)
		step_i && !load_i |-> rcon_q != 8'h00);

endmodule

// ==== logic/aes_pkg.sv ====
`include "aes_config.svh"

package aes_pkg;

	// Byte 0 of a word and word 0 of a block sit at the most significant end
	typedef logic [7:0] aes_byte_t;
	typedef aes_byte_t [0:3] aes_word_t;
	typedef aes_word_t [0:3] aes_block_t;

	typedef logic [`AES_ROUND_W-1:0] round_t;

	////////////////////////////////////////////////////////////////////////////
	// GF(2^8) arithmetic, reduction polynomial x^8 + x^4 + x^3 + x + 1
	////////////////////////////////////////////////////////////////////////////

	function automatic aes_byte_t gf_xtime(input aes_byte_t b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	// Shift and add over the bits of b
	function automatic aes_byte_t gf_mul(input aes_byte_t a, input aes_byte_t b);
		aes_byte_t acc;
		aes_byte_t p;
		acc = 8'h00;
		p = a;
		for (int i = 0; i < 8; i++)
		begin
			if (b[i])
				acc = acc ^ p;
			p = gf_xtime(p);
		end
		return acc;
	endfunction

endpackage

// ==== logic/aes_round.sv ====
`timescale 1ns/1ps

module aes_round
	import aes_pkg::*;
(
	input  aes_block_t state_i,
	input  aes_block_t round_key_i,
	input  logic       first_i,
	input  logic       last_i,
	output aes_block_t next_state_o
);

	aes_block_t sub_bytes;
	aes_block_t shift_rows;
	aes_block_t mix_cols;
	aes_block_t ark_in;

	////////////////////////////////////////////////////////////////////////////
	// SubBytes
	////////////////////////////////////////////////////////////////////////////

	genvar i;
	generate
		for (i = 0; i < 16; i++)
		begin : g_sub_bytes
			aes_sbox u_sbox (
				.byte_i(state_i[i / 4][i % 4]),
				.byte_o(sub_bytes[i / 4][i % 4])
			);
		end
	endgenerate

	////////////////////////////////////////////////////////////////////////////
	// ShiftRows and MixColumns
	////////////////////////////////////////////////////////////////////////////

	// Row r rotates left by r columns
	always_comb
	begin
		for (int c = 0; c < 4; c++)
		begin
			for (int r = 0; r < 4; r++)
				shift_rows[c][r] = sub_bytes[(c + r) % 4][r];
		end
	end

	// 2a ^ 3b written as 2(a ^ b) ^ b
	always_comb
	begin
		aes_word_t col;
		for (int c = 0; c < 4; c++)
		begin
			col = shift_rows[c];
			mix_cols[c][0] = gf_xtime(col[0] ^ col[1]) ^ col[1] ^ col[2] ^ col[3];
			mix_cols[c][1] = gf_xtime(col[1] ^ col[2]) ^ col[2] ^ col[3] ^ col[0];
			mix_cols[c][2] = gf_xtime(col[2] ^ col[3]) ^ col[3] ^ col[0] ^ col[1];
			mix_cols[c][3] = gf_xtime(col[3] ^ col[0]) ^ col[0] ^ col[1] ^ col[2];
		end
	end

	// Initial AddRoundKey, final round without MixColumns, full round
	always_comb
	begin
		if (first_i)
			ark_in = state_i;
		else if (last_i)
			ark_in = shift_rows;
		else
			ark_in = mix_cols;
	end

	assign next_state_o = ark_in ^ round_key_i;

endmodule

// ==== logic/aes_round_ctrl.sv ====
`timescale 1ns/1ps
`include "aes_config.svh"

module aes_round_ctrl
	import aes_pkg::*;
(
	input  logic clk,
	input  logic arst_n_i,
	input  logic load_i,
	output logic busy_o,
	output logic step_o,
	output logic first_o,
	output logic last_o
);

	logic   busy_q;
	round_t round_q;

	// Load wins over a step in flight and restarts the count
	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			busy_q  <= 1'b0;
			round_q <= '0;
		end
		else if (load_i)
		begin
			busy_q  <= 1'b1;
			round_q <= '0;
		end
		else if (busy_q)
		begin
			if (last_o)
			begin
				busy_q  <= 1'b0;
				round_q <= '0;
			end
			else
				round_q <= round_q + round_t'(1);
		end
	end

	assign busy_o  = busy_q;
	assign step_o  = busy_q;
	assign first_o = busy_q && (round_q == '0);
	assign last_o  = busy_q && (round_q == round_t'(`AES_NR));

	a_round_range: assert property (@(posedge clk) disable iff (!arst_n_i)
		busy_q |-> round_q <= round_t'(`AES_NR));

	a_busy_fall: assert property (@(posedge clk) disable iff (!arst_n_i)
		$fell(busy_q) |-> $past(last_o));

endmodule

// ==== logic/aes_sbox.sv ====
`timescale 1ns/1ps

module aes_sbox
	import aes_pkg::*;
(
	input  aes_byte_t byte_i,
	output aes_byte_t byte_o
);

	aes_byte_t inv;

	// Inverse as x^254 = x^2 * x^4 * ... * x^128
	// A zero input stays zero through every product
	always_comb
	begin
		aes_byte_t pw;
		aes_byte_t acc;
		pw = byte_i;
		acc = 8'h01;
		for (int i = 1; i < 8; i++)
		begin
			pw = gf_mul(pw, pw);
			acc = gf_mul(acc, pw);
		end
		inv = acc;
	end

	// Affine map x ^ rotl1 ^ rotl2 ^ rotl3 ^ rotl4 ^ 63
	assign byte_o = inv
		^ {inv[6:0], inv[7]}
		^ {inv[5:0], inv[7:6]}
		^ {inv[4:0], inv[7:5]}
		^ {inv[3:0], inv[7:4]}
		^ 8'h63;

endmodule

// ==== logic/aes_state_store.sv ====
`timescale 1ns/1ps

module aes_state_store
	import aes_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n_i,
	input  logic       load_i,
	input  logic       step_i,
	input  logic       last_i,
	input  aes_block_t data_i,
	input  aes_block_t next_state_i,
	output aes_block_t state_o,
	output aes_block_t data_o
);

	aes_block_t state_q;
	aes_block_t data_q;

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			state_q <= '0;
			data_q  <= '0;
		end
		else if (load_i)
			state_q <= data_i;
		else if (step_i)
		begin
			state_q <= next_state_i;
			// Ciphertext leaves on the final round only
			if (last_i)
				data_q <= next_state_i;
		end
	end

	assign state_o = state_q;
	assign data_o  = data_q;

	a_out_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
		!$stable(data_q) |-> $past(step_i && last_i));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the AES core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_aes_core \
	-Mdir obj_dir \
	-f all.f \
	|| { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/Vtb_aes_core)"
echo "$sim_out"

echo "$sim_out" | grep -qx "test passed" && exit 0 || exit 1

// ==== tb/tb_aes_core.sv ====
`timescale 1ns/1ps
`include "aes_config.svh"

module tb_aes_core
	import aes_pkg::*;
();

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_ROWS     = 4;
	localparam int LATENCY      = `AES_NR + 1;
	localparam int MAX_EDGES    = 2 * LATENCY;
	localparam int WATCHDOG_NS  = (RESET_CYCLES + (NUM_ROWS * 2 + 4) * 20) * CLK_PERIOD;

	logic       clk;
	logic       arst_n_i;
	logic       load_i;
	aes_block_t key_i;
	aes_block_t data_i;
	aes_block_t data_o;
	logic       busy_o;

	aes_block_t tbl_key [NUM_ROWS];
	aes_block_t tbl_pt  [NUM_ROWS];
	aes_block_t tbl_ct  [NUM_ROWS];

	int         seed;
	int         gap;
	int         mismatch_count;
	int         other_count;
	aes_block_t prev_ct;

	aes_core u_dut (
		.clk     (clk),
		.arst_n_i(arst_n_i),
		.load_i  (load_i),
		.key_i   (key_i),
		.data_i  (data_i),
		.data_o  (data_o),
		.busy_o  (busy_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Known-answer vectors
	////////////////////////////////////////////////////////////////////////////

	task automatic load_vectors();
		// FIPS-197 appendix B
		tbl_key[0] = 128'h2b7e151628aed2a6abf7158809cf4f3c;
		tbl_pt[0]  = 128'h3243f6a8885a308d313198a2e0370734;
		tbl_ct[0]  = 128'h3925841d02dc09fbdc118597196a0b32;
		// FIPS-197 appendix C.1
		tbl_key[1] = 128'h000102030405060708090a0b0c0d0e0f;
		tbl_pt[1]  = 128'h00112233445566778899aabbccddeeff;
		tbl_ct[1]  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
		// SP 800-38A ECB, first block
		tbl_key[2] = 128'h2b7e151628aed2a6abf7158809cf4f3c;
		tbl_pt[2]  = 128'h6bc1bee22e409f96e93d7e117393172a;
		tbl_ct[2]  = 128'h3ad77bb40d7a3660a89ecaf32466ef97;
		// All zero
		tbl_key[3] = 128'h0;
		tbl_pt[3]  = 128'h0;
		tbl_ct[3]  = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Checks and stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic check_block(input string name, input aes_block_t expected,
		input aes_block_t actual);
		assert (actual === expected)
		else
		begin
			mismatch_count++;
			$display("mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		assert (actual === expected)
		else
		begin
			mismatch_count++;
			$display("mismatch at %0t: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	function automatic aes_block_t random_block();
		aes_block_t blk;
		for (int w = 0; w < 4; w++)
			blk[w] = $random(seed);
		return blk;
	endfunction

	// Returns on the load edge with the operands scrambled afterwards
	task automatic start_run(input int row);
		@(posedge clk);
		load_i <= 1'b1;
		key_i  <= tbl_key[row];
		data_i <= tbl_pt[row];
		@(posedge clk);
		load_i <= 1'b0;
		key_i  <= random_block();
		data_i <= random_block();
	endtask

	// Called on the load edge; follows busy_o down and checks the result
	task automatic finish_run(input int row, input aes_block_t old_ct);
		int edges;
		edges = 0;
		@(negedge clk);
		check_bit("busy_o", 1'b1, busy_o);
		check_block("data_o", old_ct, data_o);
		while (busy_o && edges < MAX_EDGES)
		begin
			@(posedge clk);
			@(negedge clk);
			edges++;
			if (busy_o)
				check_block("data_o", old_ct, data_o);
		end
		assert (edges == LATENCY)
		else
		begin
			other_count++;
			$display("busy_o fell %0d edges after the load edge instead of %0d at %0t",
				edges, LATENCY, $time);
		end
		check_block("data_o", tbl_ct[row], data_o);
	endtask

	task automatic idle_gap();
		gap = $unsigned($random(seed)) % 4;
		repeat (gap) @(posedge clk);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		arst_n_i <= 1'b0;
		load_i   <= 1'b0;
		key_i    <= '0;
		data_i   <= '0;
		seed = 32'he744_7dcb;
		mismatch_count = 0;
		other_count = 0;
		load_vectors();

		repeat (RESET_CYCLES) @(posedge clk);
		arst_n_i <= 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_bit("busy_o", 1'b0, busy_o);
		check_block("data_o", '0, data_o);

		prev_ct = '0;
		for (int row = 0; row < NUM_ROWS; row++)
		begin
			idle_gap();
			start_run(row);
			finish_run(row, prev_ct);
			prev_ct = tbl_ct[row];
		end

		// Second load four cycles into a run
		idle_gap();
		start_run(2);
		repeat (3)
		begin
			@(negedge clk);
			check_bit("busy_o", 1'b1, busy_o);
			check_block("data_o", prev_ct, data_o);
		end
		start_run(1);
		finish_run(1, prev_ct);

		repeat (2) @(posedge clk);
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: simulation still running after %0d ns", WATCHDOG_NS);
		$display("test failed");
		$finish;
	end

endmodule
